/* source/cpu_pkg.sv */
// CPU shared definitions
// Bus widths, reset constants, condition-code layout and the opcode
// map used by the fetch unit and the accumulator ALU

package cpu_pkg;

  // --------------------
  // Bus widths
  // --------------------

  // 16-bit address bus, big-endian
  localparam int ADDR_W = 16;
  // Data bus and accumulator width
  localparam int DATA_W = 8;

  // --------------------
  // Reset constants
  // --------------------

  // Reset vector, high byte first
  localparam logic [ADDR_W-1:0] VECTOR_HI_ADDR = 16'hfffe;
  localparam logic [ADDR_W-1:0] VECTOR_LO_ADDR = 16'hffff;

  // E, F and I set out of reset
  localparam logic [7:0] CC_RESET = 8'hd0;

  // --------------------
  // Condition-code bits
  // --------------------

  localparam int CC_E = 7; // Entire state saved
  localparam int CC_F = 6; // FIRQ mask
  localparam int CC_H = 5; // Half carry
  localparam int CC_I = 4; // IRQ mask
  localparam int CC_N = 3; // Negative
  localparam int CC_Z = 2; // Zero
  localparam int CC_V = 1; // Overflow
  localparam int CC_C = 0; // Carry

  // --------------------
  // Opcode map
  // --------------------

  // Inherent rows, operand and destination in the row
  localparam logic [3:0] ROW_INH_A = 4'h4;
  localparam logic [3:0] ROW_INH_B = 4'h5;

  // Columns of the accumulator operations
  localparam logic [3:0] COL_COM = 4'h3;
  localparam logic [3:0] COL_LSR = 4'h4;
  localparam logic [3:0] COL_ASR = 4'h7;
  localparam logic [3:0] COL_ASL = 4'h8; // LSL shares this column
  localparam logic [3:0] COL_INC = 4'hc;
  localparam logic [3:0] COL_CLR = 4'hf;

  // Row in the upper nibble, column in the lower
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } opcode_fields_t;

  // Opcode byte, seen whole or as row/column
  typedef union packed {
    logic [DATA_W-1:0] raw;
    opcode_fields_t    f;
  } opcode_t;

endpackage

/* source/cpu_fetch.sv */
// CPU fetch unit
// Reads the reset vector, then fetches one opcode per cycle
// from the program counter into the instruction register

`timescale 1ns/100ps

module cpu_fetch (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic [cpu_pkg::DATA_W-1:0] data_in,
  output logic [cpu_pkg::ADDR_W-1:0] addr,
  output cpu_pkg::opcode_t           ir,
  output logic                       ir_valid
);

  import cpu_pkg::*;

  // --------------------
  // State machine
  // --------------------

  // Each state names what the previous bus cycle completed
  localparam logic [1:0] ST_RESET  = 2'd0; // Vector high byte on the bus
  localparam logic [1:0] ST_VEC_HI = 2'd1; // High byte held, low byte on bus
  localparam logic [1:0] ST_VEC_LO = 2'd2; // Vector loaded, first opcode
  localparam logic [1:0] ST_RUN    = 2'd3; // Sequential opcode fetch

  logic [1:0]        state;
  logic [1:0]        state_next;
  // Address of the byte after the one on the bus
  logic [ADDR_W-1:0] pc;
  // Vector as it lands from the low-byte read
  logic [ADDR_W-1:0] vector;
  // An opcode is on the bus this cycle
  logic              fetch_op;

  assign fetch_op = (state == ST_VEC_LO) || (state == ST_RUN);
  assign vector   = {pc[ADDR_W-1:DATA_W], data_in};

  always_comb begin
    case (state)
      ST_RESET:  state_next = ST_VEC_HI;
      ST_VEC_HI: state_next = ST_VEC_LO;
      ST_VEC_LO: state_next = ST_RUN;
      default:   state_next = ST_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= ST_RESET;
    end else begin
      state <= state_next;
    end
  end

  // --------------------
  // Address and PC
  // --------------------

  // Bus address is registered, reset parks it on the vector
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      addr <= VECTOR_HI_ADDR;
      pc   <= '0;
    end else begin
      case (state)
        ST_RESET: begin
          // Big-endian, high byte comes first
          addr <= VECTOR_LO_ADDR;
          pc   <= {data_in, {DATA_W{1'b0}}};
        end
        ST_VEC_HI: begin
          addr <= vector;
          pc   <= vector + 1'b1;
        end
        default: begin
          // One-byte opcodes only, so always step by one
          addr <= pc;
          pc   <= pc + 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // Instruction register
  // --------------------

  // Opcode byte latched whole, decoded by row/column downstream
  always_ff @(posedge clk) begin
    if (fetch_op) begin
      ir.raw <= data_in;
    end
  end

  // Marks a freshly latched opcode in ir
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      ir_valid <= 1'b0;
    end else begin
      ir_valid <= fetch_op;
    end
  end

endmodule

/* source/cpu_alu.sv */
// CPU accumulator ALU
// Decodes the inherent A/B operations from the opcode and produces
// the result, the next condition codes and the register write enables

`timescale 1ns/100ps

module cpu_alu (
  input  cpu_pkg::opcode_t           ir,
  input  logic                       ir_valid,
  input  logic [cpu_pkg::DATA_W-1:0] acc_a,
  input  logic [cpu_pkg::DATA_W-1:0] acc_b,
  input  logic [7:0]                 cc,
  output logic [cpu_pkg::DATA_W-1:0] result,
  output logic [7:0]                 cc_next,
  output logic                       wr_a,
  output logic                       wr_b,
  output logic                       cc_wr,
  output logic                       issue
);

  import cpu_pkg::*;

  // --------------------
  // Operand select
  // --------------------

  // Row picks the accumulator, source and destination alike
  logic              sel_a;
  logic              sel_b;
  logic [DATA_W-1:0] operand;

  assign sel_a   = (ir.f.row == ROW_INH_A);
  assign sel_b   = (ir.f.row == ROW_INH_B);
  assign operand = sel_b ? acc_b : acc_a;

  // --------------------
  // Operation
  // --------------------

  // Column picks the operation
  logic op_kept;
  logic flag_v;
  logic flag_c;
  logic flag_n;
  logic flag_z;

  always_comb begin
    // V and C hold unless the operation defines them
    op_kept = 1'b1;
    flag_v  = cc[CC_V];
    flag_c  = cc[CC_C];
    case (ir.f.col)
      COL_CLR: begin
        result = '0;
        flag_v = 1'b0;
        flag_c = 1'b0;
      end
      COL_INC: begin
        // Wraps at FF, carry untouched
        result = operand + 1'b1;
        flag_v = (operand == 8'h7f);
      end
      COL_ASL: begin
        result = {operand[DATA_W-2:0], 1'b0};
        flag_c = operand[DATA_W-1];
        // Sign changed by the shift
        flag_v = operand[DATA_W-1] ^ operand[DATA_W-2];
      end
      COL_ASR: begin
        // Sign bit replicated
        result = {operand[DATA_W-1], operand[DATA_W-1:1]};
        flag_c = operand[0];
      end
      COL_LSR: begin
        result = {1'b0, operand[DATA_W-1:1]};
        flag_c = operand[0];
      end
      COL_COM: begin
        result = ~operand;
        flag_v = 1'b0;
        flag_c = 1'b1;
      end
      default: begin
        // Not an accumulator op, runs as a no-op
        result  = operand;
        op_kept = 1'b0;
      end
    endcase
  end

  // N and Z straight from the result
  // CLR gives N=0 Z=1, LSR always shifts a 0 into N
  assign flag_n = result[DATA_W-1];
  assign flag_z = (result == '0);

  // --------------------
  // Condition codes
  // --------------------

  // E, F, H and I pass through unchanged
  always_comb begin
    cc_next       = cc;
    cc_next[CC_N] = flag_n;
    cc_next[CC_Z] = flag_z;
    cc_next[CC_V] = flag_v;
    cc_next[CC_C] = flag_c;
  end

  // --------------------
  // Write enables
  // --------------------

  // Only a kept row/column pair writes, and only on a valid opcode
  assign wr_a  = ir_valid & op_kept & sel_a;
  assign wr_b  = ir_valid & op_kept & sel_b;
  assign cc_wr = ir_valid & op_kept & (sel_a | sel_b);

  // Every valid opcode retires, no-ops included
  assign issue = ir_valid;

endmodule

/* source/cpu_regs.sv */
// CPU register block
// Architectural A, B and CC registers loaded from the ALU,
// plus the retire flag one cycle behind execute

`timescale 1ns/100ps

module cpu_regs (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic [cpu_pkg::DATA_W-1:0] result,
  input  logic [7:0]                 cc_next,
  input  logic                       wr_a,
  input  logic                       wr_b,
  input  logic                       cc_wr,
  input  logic                       issue,
  output logic [cpu_pkg::DATA_W-1:0] acc_a,
  output logic [cpu_pkg::DATA_W-1:0] acc_b,
  output logic [7:0]                 cc,
  output logic                       retire
);

  import cpu_pkg::*;

  // --------------------
  // Accumulators
  // --------------------

  // Both cleared out of reset
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      acc_a <= '0;
      acc_b <= '0;
    end else begin
      // At most one of these per cycle
      if (wr_a) begin
        acc_a <= result;
      end
      if (wr_b) begin
        acc_b <= result;
      end
    end
  end

  // --------------------
  // Condition codes
  // --------------------

  // Interrupt masks come up set
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      cc <= CC_RESET;
    end else if (cc_wr) begin
      cc <= cc_next;
    end
  end

  // --------------------
  // Retire
  // --------------------

  // Lines up with the register update it reports
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      retire <= 1'b0;
    end else begin
      retire <= issue;
    end
  end

endmodule

/* source/cpu_core.sv */
// CPU core top level
// Fetch, accumulator ALU and register block on a read-only bus,
// with register contents and retire brought out for observation

`timescale 1ns/100ps

module cpu_core (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic [cpu_pkg::DATA_W-1:0] data_in,
  output logic [cpu_pkg::ADDR_W-1:0] addr,
  output logic [cpu_pkg::DATA_W-1:0] acc_a,
  output logic [cpu_pkg::DATA_W-1:0] acc_b,
  output logic [7:0]                 cc,
  output logic                       retire
);

  import cpu_pkg::*;

  // Fetch to execute
  opcode_t           ir;
  logic              ir_valid;

  // Execute to registers
  logic [DATA_W-1:0] result;
  logic [7:0]        cc_next;
  logic              wr_a;
  logic              wr_b;
  logic              cc_wr;
  logic              issue;

  // Vector read, then one opcode per cycle
  cpu_fetch u_fetch (
    .clk      (clk),
    .reset_b  (reset_b),
    .data_in  (data_in),
    .addr     (addr),
    .ir       (ir),
    .ir_valid (ir_valid)
  );

  // Combinational execute stage
  cpu_alu u_alu (
    .ir       (ir),
    .ir_valid (ir_valid),
    .acc_a    (acc_a),
    .acc_b    (acc_b),
    .cc       (cc),
    .result   (result),
    .cc_next  (cc_next),
    .wr_a     (wr_a),
    .wr_b     (wr_b),
    .cc_wr    (cc_wr),
    .issue    (issue)
  );

  // Architectural state, also the observation ports
  cpu_regs u_regs (
    .clk      (clk),
    .reset_b  (reset_b),
    .result   (result),
    .cc_next  (cc_next),
    .wr_a     (wr_a),
    .wr_b     (wr_b),
    .cc_wr    (cc_wr),
    .issue    (issue),
    .acc_a    (acc_a),
    .acc_b    (acc_b),
    .cc       (cc),
    .retire   (retire)
  );

endmodule

/* tests/cpu_chk.sv */
// Fetch and write-enable checker
// Watches address sequencing and the ALU register enables

`timescale 1ns/100ps

module cpu_chk (
  input logic                       clk,
  input logic                       reset_b,
  input logic [cpu_pkg::ADDR_W-1:0] addr,
  input logic                       ir_valid,
  input logic                       wr_a,
  input logic                       wr_b,
  input logic                       cc_wr
);

  import cpu_pkg::*;

  // --------------------
  // Fetch sequencing
  // --------------------

  // Valid opcode means sequential fetch, one byte per cycle
  a_addr_step: assert property (
    @(posedge clk) disable iff (!reset_b)
    ir_valid |-> (addr == $past(addr) + ADDR_W'(1))
  ) else $error("address did not advance by one during sequential fetch");

  // --------------------
  // Write enables
  // --------------------

  // One accumulator per opcode
  a_one_acc: assert property (
    @(posedge clk) disable iff (!reset_b)
    !(wr_a && wr_b)
  ) else $error("both accumulators written in the same cycle");

  // No write without a fetched opcode behind it
  a_no_stray_write: assert property (
    @(posedge clk) disable iff (!reset_b)
    !ir_valid |-> !(wr_a || wr_b || cc_wr)
  ) else $error("register write enable raised without a valid opcode");

endmodule

// Attached at the core, where fetch and ALU signals meet
bind cpu_core cpu_chk u_chk (
  .clk      (clk),
  .reset_b  (reset_b),
  .addr     (addr),
  .ir_valid (ir_valid),
  .wr_a     (wr_a),
  .wr_b     (wr_b),
  .cc_wr    (cc_wr)
);

/* tests/tb_cpu.sv */
// CPU core testbench
// Runs an opcode table from memory through the core and checks
// each retired instruction against a reference model

`timescale 1ns/100ps

module tb_cpu;

  import cpu_pkg::*;

  localparam int          N_DIRECTED     = 40;
  localparam int          N_RANDOM       = 40;
  localparam int          N_ROWS         = N_DIRECTED + N_RANDOM;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + N_ROWS + 20;
  localparam logic [15:0] PROG_START     = 16'h0100;

  // Flag edges with no-ops 12, 4A and 89 mixed in
  localparam logic [7:0] DIRECTED [N_DIRECTED] = '{
    8'h4f, 8'h5f, 8'h12, 8'h43, 8'h44, 8'h4c, 8'h4a, 8'h47, 8'h48, 8'h48,
    8'h89, 8'h4c, 8'h5c, 8'h58, 8'h58, 8'h58, 8'h58, 8'h58, 8'h58, 8'h58,
    8'h57, 8'h53, 8'h54, 8'h12, 8'h54, 8'h54, 8'h54, 8'h54, 8'h54, 8'h4a,
    8'h5c, 8'h47, 8'h43, 8'h4c, 8'h89, 8'h5f, 8'h53, 8'h58, 8'h57, 8'h12
  };
  // Kept A and B operations followed by three no-ops
  localparam logic [7:0] OP_POOL [15] = '{
    8'h43, 8'h44, 8'h47, 8'h48, 8'h4c, 8'h4f, 8'h53, 8'h54,
    8'h57, 8'h58, 8'h5c, 8'h5f, 8'h12, 8'h4a, 8'h89
  };

  logic              clk;
  logic              reset_b;
  logic [DATA_W-1:0] data_in;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] acc_a;
  logic [DATA_W-1:0] acc_b;
  logic [7:0]        cc;
  logic              retire;

  // Program memory and the expected state per row
  logic [7:0] mem [0:65535];
  logic [7:0] tab_op [N_ROWS];
  logic [7:0] tab_a [N_ROWS];
  logic [7:0] tab_b [N_ROWS];
  logic [7:0] tab_cc [N_ROWS];
  // Model registers
  logic [7:0] m_a;
  logic [7:0] m_b;
  logic [7:0] m_cc;
  integer     seed;
  int         cycle_count = 0;

  cpu_core u_dut (
    .clk     (clk),
    .reset_b (reset_b),
    .data_in (data_in),
    .addr    (addr),
    .acc_a   (acc_a),
    .acc_b   (acc_b),
    .cc      (cc),
    .retire  (retire)
  );

  // --------------------
  // Clock, memory and timeout
  // --------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Read port answers for the address the core holds this cycle
  always @(posedge clk) begin
    #1;
    data_in = mem[addr];
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run("timeout, the table did not retire within the cycle limit");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
    else abort_run($sformatf("error at %0t ns: %s expected %0h, actual %0h",
                             $time, name, expected, actual));
  endtask

  // --------------------
  // Reference model
  // --------------------

  // One opcode against model A, B and CC
  task automatic model_step(input logic [7:0] op);
    logic [7:0] v;
    logic [7:0] r;
    logic       nv;
    logic       nc;
    logic       kept;
    v    = (op[7:4] == 4'h5) ? m_b : m_a;
    r    = v;
    nv   = m_cc[CC_V];
    nc   = m_cc[CC_C];
    kept = (op[7:4] == 4'h4) || (op[7:4] == 4'h5);
    case (op[3:0])
      4'hf: begin
        r  = 8'h00;
        nv = 1'b0;
        nc = 1'b0;
      end
      4'hc: begin
        // Carry left alone
        r  = v + 8'd1;
        nv = (v == 8'h7f);
      end
      4'h8: begin
        r  = {v[6:0], 1'b0};
        nc = v[7];
        nv = v[7] ^ v[6];
      end
      4'h7: begin
        r  = {v[7], v[7:1]};
        nc = v[0];
      end
      4'h4: begin
        r  = {1'b0, v[7:1]};
        nc = v[0];
      end
      4'h3: begin
        r  = ~v;
        nv = 1'b0;
        nc = 1'b1;
      end
      default: begin
        kept = 1'b0;
      end
    endcase
    if (kept) begin
      if (op[7:4] == 4'h4) begin
        m_a = r;
      end else begin
        m_b = r;
      end
      // Upper nibble never moves
      m_cc = {m_cc[7:4], r[7], (r == 8'h00), nv, nc};
    end
  endtask

  task automatic build_table();
    int pick;
    seed = 95;
    m_a  = 8'h00;
    m_b  = 8'h00;
    m_cc = CC_RESET;
    for (int k = 0; k < N_ROWS; k++) begin
      if (k < N_DIRECTED) begin
        tab_op[k] = DIRECTED[k];
      end else begin
        pick      = $unsigned($random(seed)) % 15;
        tab_op[k] = OP_POOL[pick];
      end
      model_step(tab_op[k]);
      tab_a[k]  = m_a;
      tab_b[k]  = m_b;
      tab_cc[k] = m_cc;
    end
  endtask

  task automatic load_memory();
    logic [15:0] a;
    for (int i = 0; i < 65536; i++) begin
      a = 16'(i);
      // Filler mixes both address bytes
      mem[i] = a[15:8] ^ a[7:0] ^ 8'ha5;
    end
    mem[VECTOR_HI_ADDR] = PROG_START[15:8];
    mem[VECTOR_LO_ADDR] = PROG_START[7:0];
    for (int k = 0; k < N_ROWS; k++) begin
      mem[PROG_START + 16'(k)] = tab_op[k];
    end
  endtask

  // --------------------
  // Checks
  // --------------------

  task automatic check_reset_state();
    check_value("addr", VECTOR_HI_ADDR, addr);
    check_value("retire", 16'd0, 16'(retire));
    check_value("acc_a", 16'd0, 16'(acc_a));
    check_value("acc_b", 16'd0, 16'(acc_b));
    check_value("cc", 16'(CC_RESET), 16'(cc));
  endtask

  // Row k retires while the core fetches two bytes ahead
  task automatic check_row(input int k);
    check_value("retire", 16'd1, 16'(retire));
    check_value("addr", PROG_START + 16'(k + 2), addr);
    check_value("acc_a", 16'(tab_a[k]), 16'(acc_a));
    check_value("acc_b", 16'(tab_b[k]), 16'(acc_b));
    // E, F, H and I against reset before the full compare
    check_value("cc[7:4]", 16'(CC_RESET[7:4]), 16'(cc[7:4]));
    check_value("cc", 16'(tab_cc[k]), 16'(cc));
  endtask

  initial begin
    reset_b = 1'b0;
    data_in = 8'h00;
    build_table();
    load_memory();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #1;
    reset_b = 1'b1;
    // Still on the vector until the next edge
    @(negedge clk);
    check_reset_state();
    @(negedge clk);
    check_value("addr", VECTOR_LO_ADDR, addr);
    @(negedge clk);
    check_value("addr", PROG_START, addr);
    check_value("retire", 16'd0, 16'(retire));
    @(negedge clk);
    check_value("addr", PROG_START + 16'd1, addr);
    check_value("retire", 16'd0, 16'(retire));
    for (int k = 0; k < N_ROWS; k++) begin
      @(negedge clk);
      check_row(k);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_alu.sv
source/cpu_regs.sv
source/cpu_core.sv
tests/cpu_chk.sv
tests/tb_cpu.sv

/* Makefile */
# Verilator build and run of the CPU core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

# Sources come from the file list, so the binary tracks every edit
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
